// ==== logic/code_matcher.sv ====
`timescale 1ns/1ps

module code_matcher (
  input  lock_types_pkg::code_t entry_value,
  input  lock_types_pkg::code_t codes    [lock_cfg_pkg::NUM_CODES],
  input  lock_types_pkg::len_t  code_len [lock_cfg_pkg::NUM_CODES],
  output logic                  code_match
);

  import lock_cfg_pkg::*;
  import lock_types_pkg::*;

  // One bit per slot and start position in the entry.
  logic [NUM_CODES-1:0][CODE_DIGITS-MIN_CODE_LEN:0] shift_hit;

  for (genvar s = 0; s < NUM_CODES; s++) begin : g_slot
    for (genvar k = 0; k <= CODE_DIGITS - MIN_CODE_LEN; k++) begin : g_shift
      logic [MAX_CODE_LEN-1:0] digit_ok;

      for (genvar j = 0; j < MAX_CODE_LEN; j++) begin : g_digit
        if (k + j < CODE_DIGITS) begin : g_in_range
          assign digit_ok[j] = (code_len[s] <= len_t'(j)) ||
                               (entry_value[k+j] == codes[s][j]);
        end
        else begin : g_past_end
          // The code may not run past the oldest entry digit.
          assign digit_ok[j] = code_len[s] <= len_t'(j);
        end
      end

      assign shift_hit[s][k] = (code_len[s] != '0) && (&digit_ok);
    end
  end

  assign code_match = |shift_hit;

endmodule

// ==== logic/code_store.sv ====
`timescale 1ns/1ps

module code_store (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  code_load,
  input  lock_types_pkg::code_t code_in  [lock_cfg_pkg::NUM_CODES],
  output lock_types_pkg::code_t codes    [lock_cfg_pkg::NUM_CODES],
  output lock_types_pkg::len_t  code_len [lock_cfg_pkg::NUM_CODES]
);

  import lock_cfg_pkg::*;
  import lock_types_pkg::*;

  // Length is the count of digits below the first empty one.
  // Out-of-range lengths leave the slot empty.
  function automatic len_t valid_length(code_t code);
    int n;
    n = CODE_DIGITS;
    for (int i = CODE_DIGITS - 1; i >= 0; i--) begin
      if (code[i] == DIGIT_EMPTY) begin
        n = i;
      end
    end
    if (n < MIN_CODE_LEN || n > MAX_CODE_LEN) begin
      return '0;
    end
    return len_t'(n);
  endfunction

  //////////////////////////////////////////////////
  // Code digits
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (code_load) begin
      codes <= code_in;
    end
  end

  //////////////////////////////////////////////////
  // Slot lengths
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int s = 0; s < NUM_CODES; s++) begin
        code_len[s] <= '0;  // All slots empty.
      end
    end
    else if (code_load) begin
      for (int s = 0; s < NUM_CODES; s++) begin
        code_len[s] <= valid_length(code_in[s]);
      end
    end
  end

endmodule

// ==== logic/door_fsm.sv ====
`timescale 1ns/1ps

module door_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     door_open,
  input  logic                     inside_button,
  input  logic                     entry_valid,
  input  lock_types_pkg::code_t    entry_value,
  input  logic                     code_match,
  output logic                     bolt,
  output logic                     beep,
  output logic                     keypad_en,
  output lock_types_pkg::display_t display
);

  import lock_cfg_pkg::*;
  import lock_types_pkg::*;

  lock_state_t        state;
  logic [TIMER_W-1:0] timer;  // Shared by every timed state.
  logic [TRIES_W-1:0] tries;
  logic               entry_error;
  logic               entry_confirm;

  assign entry_error   = entry_valid && (entry_value[0] == DIGIT_ERROR);
  assign entry_confirm = entry_valid && (entry_value[0] != DIGIT_ERROR);

  // Lit marks filled from the right.
  function automatic display_t mark_display(logic [TRIES_W-1:0] count);
    display_t disp;
    disp = DISPLAY_BLANK;
    for (int i = 0; i < DISPLAY_DIGITS; i++) begin
      if (i < int'(count)) begin
        disp[i] = DIGIT_MARK;
      end
    end
    return disp;
  endfunction

  //////////////////////////////////////////////////
  // State, timer and tries
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= reset_st;
      timer <= '0;
      tries <= '0;
    end
    else begin
      case (state)
        reset_st: begin
          if (!door_open) begin
            state <= locked;
            tries <= '0;
          end
        end
        locked: begin
          // Error beats button, button beats confirm.
          if (entry_error) begin
            state <= entry_beep;
            timer <= '0;
          end
          else if (inside_button) begin
            state <= debounce_unlock;
            timer <= '0;
          end
          else if (entry_confirm) begin
            state <= check_code;
            tries <= tries + 1'b1;
          end
        end
        check_code: begin
          timer <= '0;
          state <= code_match ? ajar : wrong_code;
        end
        wrong_code: begin
          if (timer < TIMER_W'(WRONG_CYCLES)) begin
            timer <= timer + 1'b1;
          end
          else if (tries >= TRIES_W'(MAX_TRIES)) begin
            state <= lockout;
            timer <= '0;
          end
          else begin
            state <= locked;
          end
        end
        lockout: begin
          if (timer < TIMER_W'(LOCKOUT_CYCLES)) begin
            timer <= timer + 1'b1;
          end
          else begin
            state <= locked;
            tries <= '0;
          end
        end
        entry_beep: begin
          if (timer < TIMER_W'(BEEP_CYCLES)) begin
            timer <= timer + 1'b1;
          end
          else begin
            state <= locked;
          end
        end
        debounce_unlock: begin
          if (timer >= TIMER_W'(DEBOUNCE_CYCLES)) begin
            state <= ajar;
            timer <= '0;
          end
          else if (!inside_button) begin
            state <= locked;  // Released too early.
          end
          else begin
            timer <= timer + 1'b1;
          end
        end
        debounce_lock: begin
          if (timer >= TIMER_W'(DEBOUNCE_CYCLES)) begin
            state <= locked;
          end
          else if (!inside_button) begin
            state <= ajar;
            timer <= '0;  // Auto-lock count starts over.
          end
          else begin
            timer <= timer + 1'b1;
          end
        end
        ajar: begin
          if (inside_button) begin
            state <= debounce_lock;
            timer <= '0;
          end
          else if (door_open) begin
            state <= open_door;
            timer <= '0;
          end
          else if (timer >= TIMER_W'(AUTO_LOCK_CYCLES)) begin
            state <= locked;
          end
          else begin
            timer <= timer + 1'b1;
          end
        end
        open_door: begin
          if (!door_open) begin
            state <= ajar;
            timer <= '0;
          end
          else if (timer >= TIMER_W'(OPEN_ALARM_CYCLES)) begin
            state <= open_alarm;
          end
          else begin
            timer <= timer + 1'b1;
          end
        end
        open_alarm: begin
          if (!door_open) begin
            state <= ajar;
            timer <= '0;
          end
        end
        default: state <= reset_st;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  always_comb begin
    bolt      = 1'b1;
    beep      = 1'b0;
    keypad_en = 1'b0;
    display   = DISPLAY_BLANK;
    case (state)
      locked:                       keypad_en = 1'b1;
      ajar, open_door, debounce_lock: bolt = 1'b0;
      open_alarm: begin
        bolt = 1'b0;
        beep = 1'b1;
      end
      entry_beep:                   beep = 1'b1;
      wrong_code:                   display = mark_display(tries);
      lockout:                      display = mark_display(TRIES_W'(MAX_TRIES));
      check_code, debounce_unlock:  bolt = 1'b1;  // Still bolted while deciding.
      default:                      bolt = 1'b0;  // Reset state.
    endcase
  end

endmodule

// ==== logic/door_lock_top.sv ====
`timescale 1ns/1ps

module door_lock_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     door_open,
  input  logic                     inside_button,
  input  logic                     code_load,
  input  lock_types_pkg::code_t    code_in [lock_cfg_pkg::NUM_CODES],
  input  lock_types_pkg::code_t    entry_value,
  input  logic                     entry_valid,
  output logic                     bolt,
  output logic                     beep,
  output logic                     keypad_en,
  output lock_types_pkg::display_t display
);

  import lock_cfg_pkg::*;
  import lock_types_pkg::*;

  code_t codes    [NUM_CODES];
  len_t  code_len [NUM_CODES];
  logic  code_match;

  //////////////////////////////////////////////////
  // Stored codes and the entry compare
  //////////////////////////////////////////////////

  code_store code_store_i (
    .clk       (clk),
    .rst       (rst),
    .code_load (code_load),
    .code_in   (code_in),
    .codes     (codes),
    .code_len  (code_len)
  );

  code_matcher code_matcher_i (
    .entry_value (entry_value),
    .codes       (codes),
    .code_len    (code_len),
    .code_match  (code_match)
  );

  //////////////////////////////////////////////////
  // Lock control
  //////////////////////////////////////////////////

  door_fsm door_fsm_i (
    .clk           (clk),
    .rst           (rst),
    .door_open     (door_open),
    .inside_button (inside_button),
    .entry_valid   (entry_valid),
    .entry_value   (entry_value),
    .code_match    (code_match),
    .bolt          (bolt),
    .beep          (beep),
    .keypad_en     (keypad_en),
    .display       (display)
  );

endmodule

// ==== logic/lock_cfg_pkg.sv ====
package lock_cfg_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int NUM_CODES   = 4;   // User code slots.
  localparam int CODE_DIGITS = 20;  // Digits in a stored code or a keypad entry.

  localparam int MIN_CODE_LEN = 4;
  localparam int MAX_CODE_LEN = 12;

  //////////////////////////////////////////////////
  // Timing, in clock cycles
  //////////////////////////////////////////////////

  localparam int DEBOUNCE_CYCLES   = 4;   // Inside button hold time.
  localparam int BEEP_CYCLES       = 5;   // Keypad error beep.
  localparam int WRONG_CYCLES      = 10;  // Wrong-code display time.
  localparam int LOCKOUT_CYCLES    = 30;
  localparam int AUTO_LOCK_CYCLES  = 20;  // Door closed and unbolted.
  localparam int OPEN_ALARM_CYCLES = 15;  // Door open before the beep.

  localparam int MAX_TRIES = 5;  // Wrong codes before lockout.

  // Shared timer must hold the longest limit.
  localparam int LIMIT_A = (DEBOUNCE_CYCLES > BEEP_CYCLES) ? DEBOUNCE_CYCLES : BEEP_CYCLES;
  localparam int LIMIT_B = (WRONG_CYCLES > LOCKOUT_CYCLES) ? WRONG_CYCLES : LOCKOUT_CYCLES;
  localparam int LIMIT_C = (AUTO_LOCK_CYCLES > OPEN_ALARM_CYCLES) ?
                           AUTO_LOCK_CYCLES : OPEN_ALARM_CYCLES;
  localparam int LIMIT_AB = (LIMIT_A > LIMIT_B) ? LIMIT_A : LIMIT_B;
  localparam int LONGEST_LIMIT = (LIMIT_AB > LIMIT_C) ? LIMIT_AB : LIMIT_C;

  localparam int TIMER_W = $clog2(LONGEST_LIMIT + 1);
  localparam int TRIES_W = $clog2(MAX_TRIES + 1);

endpackage

// ==== logic/lock_types_pkg.sv ====
package lock_types_pkg;

  //////////////////////////////////////////////////
  // Keypad digits
  //////////////////////////////////////////////////

  // 0 to 9 are keys, the rest are markers.
  typedef logic [3:0] digit_t;

  localparam digit_t DIGIT_MARK  = 4'hA;  // Lit mark on the display.
  localparam digit_t DIGIT_BLANK = 4'hB;
  localparam digit_t DIGIT_ERROR = 4'hE;  // Keypad error in digit 0.
  localparam digit_t DIGIT_EMPTY = 4'hF;  // Unused code position.

  // Digit 0 is the newest one.
  typedef digit_t [lock_cfg_pkg::CODE_DIGITS-1:0] code_t;

  typedef logic [3:0] len_t;  // Zero marks an empty slot.

  //////////////////////////////////////////////////
  // Display
  //////////////////////////////////////////////////

  localparam int DISPLAY_DIGITS = 6;

  typedef digit_t [DISPLAY_DIGITS-1:0] display_t;

  localparam display_t DISPLAY_BLANK = {DISPLAY_DIGITS{DIGIT_BLANK}};

  //////////////////////////////////////////////////
  // Door state machine
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    reset_st,
    locked,
    ajar,
    open_door,
    open_alarm,
    check_code,
    wrong_code,
    lockout,
    entry_beep,
    debounce_unlock,
    debounce_lock
  } lock_state_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the door lock testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module door_lock_tb -f src.f -o door_lock_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/door_lock_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

// ==== sim/door_lock_properties.sv ====
`timescale 1ns/1ps

module door_lock_properties (
  input logic                        clk,
  input logic                        rst,
  input lock_types_pkg::lock_state_t state,
  input logic                        bolt,
  input logic                        beep,
  input logic                        keypad_en
);

  import lock_types_pkg::*;

  //////////////////////////////////////////////////
  // Output rules per state
  //////////////////////////////////////////////////

  bolt_in_lockout: assert property (
    @(posedge clk) disable iff (rst) (state == lockout) |-> bolt
  ) else $error("bolt low during lockout");

  // Keypad only listens while locked.
  keypad_only_locked: assert property (
    @(posedge clk) disable iff (rst) (state != locked) |-> !keypad_en
  ) else $error("keypad_en high outside locked");

  beep_only_when_due: assert property (
    @(posedge clk) disable iff (rst)
      (state != entry_beep && state != open_alarm) |-> !beep
  ) else $error("beep high outside entry_beep and open_alarm");

endmodule

bind door_fsm door_lock_properties door_lock_properties_i (
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .bolt      (bolt),
  .beep      (beep),
  .keypad_en (keypad_en)
);

// ==== sim/door_lock_tb.sv ====
`timescale 1ns/1ps

module door_lock_tb;

  import lock_cfg_pkg::*;
  import lock_types_pkg::*;

  //////////////////////////////////////////////////
  // Run length budget
  //////////////////////////////////////////////////

  localparam int WAIT_LIMIT = AUTO_LOCK_CYCLES + DEBOUNCE_CYCLES + 10;
  localparam int T_RESET    = 4;
  localparam int T_OPEN     = T_RESET + 8;
  localparam int T_WRONG    = T_RESET + MAX_TRIES * (WRONG_CYCLES + 4) + LOCKOUT_CYCLES + 10;
  localparam int T_BEEP     = T_RESET + BEEP_CYCLES + WRONG_CYCLES + 10 + WAIT_LIMIT;
  localparam int T_BUTTON   = T_RESET + 4 * (DEBOUNCE_CYCLES + 3);
  localparam int T_DOOR     = T_RESET + 2 * (DEBOUNCE_CYCLES + 3) + AUTO_LOCK_CYCLES +
                              OPEN_ALARM_CYCLES + WAIT_LIMIT + 8;
  localparam int T_LOAD     = T_RESET + WRONG_CYCLES + WAIT_LIMIT + 12;
  localparam int TIMEOUT    = 2 * (T_OPEN + T_WRONG + T_BEEP + T_BUTTON + T_DOOR + T_LOAD);

  logic     clk;
  logic     rst;
  logic     door_open;
  logic     inside_button;
  logic     code_load;
  code_t    code_in [NUM_CODES];
  code_t    entry_value;
  logic     entry_valid;
  logic     bolt;
  logic     beep;
  logic     keypad_en;
  display_t display;

  int cycles;
  int tries_exp;  // Confirmed entries since the last clear.

  tb_clock clock_i (.clk(clk));

  door_lock_top door_lock_top_i (
    .clk           (clk),
    .rst           (rst),
    .door_open     (door_open),
    .inside_button (inside_button),
    .code_load     (code_load),
    .code_in       (code_in),
    .entry_value   (entry_value),
    .entry_valid   (entry_valid),
    .bolt          (bolt),
    .beep          (beep),
    .keypad_en     (keypad_en),
    .display       (display)
  );

  //////////////////////////////////////////////////
  // Reporting and checks
  //////////////////////////////////////////////////

  task automatic stop_on_error(string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_bit(string name, logic actual, logic expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic check_display(display_t actual, display_t expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAILED display: got 0x%06h, expected 0x%06h",
                              actual, expected));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT) begin
      stop_on_error("Timeout: the tests did not finish in the expected number of cycles.");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic display_t marks(int n);
    display_t d;
    d = DISPLAY_BLANK;
    for (int i = 0; i < n; i++) begin
      d[i] = 4'hA;
    end
    return d;
  endfunction

  function automatic code_t random_code(int len);
    code_t c;
    c = '1;  // All positions empty.
    for (int j = 0; j < len; j++) begin
      c[j] = digit_t'($urandom_range(0, 9));
    end
    return c;
  endfunction

  // Ghost digits around the code at the given start position.
  function automatic code_t ghost_entry(code_t code, int len, int shift);
    code_t e;
    for (int j = 0; j < CODE_DIGITS; j++) begin
      e[j] = digit_t'($urandom_range(0, 9));
    end
    for (int j = 0; j < len; j++) begin
      e[shift+j] = code[j];
    end
    return e;
  endfunction

  // No digit equals the first code digit, so no shift can match.
  function automatic code_t miss_entry(digit_t avoid);
    code_t e;
    digit_t d;
    for (int j = 0; j < CODE_DIGITS; j++) begin
      d = digit_t'($urandom_range(0, 8));
      if (d >= avoid) begin
        d = d + 1'b1;
      end
      e[j] = d;
    end
    return e;
  endfunction

  task automatic reset_dut();
    rst           = 1'b1;
    door_open     = 1'b0;
    inside_button = 1'b0;
    code_load     = 1'b0;
    entry_valid   = 1'b0;
    entry_value   = '1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    tries_exp = 0;
    check_bit("bolt", bolt, 1'b1);
    check_bit("keypad_en", keypad_en, 1'b1);
    check_display(display, DISPLAY_BLANK);
  endtask

  task automatic load_codes(code_t c0, code_t c1, code_t c2, code_t c3);
    code_in[0] = c0;
    code_in[1] = c1;
    code_in[2] = c2;
    code_in[3] = c3;
    code_load  = 1'b1;
    @(negedge clk);
    code_load = 1'b0;
  endtask

  // Returns one cycle after the pulse; the value stays on the bus.
  task automatic send_entry(code_t e);
    entry_value = e;
    entry_valid = 1'b1;
    @(negedge clk);
    entry_valid = 1'b0;
  endtask

  task automatic wait_locked();
    int n;
    n = 0;
    while (keypad_en !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        stop_on_error("The lock did not return to the locked state in time.");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic press_button(int n);
    inside_button = 1'b1;
    repeat (n) @(negedge clk);
    inside_button = 1'b0;
    @(negedge clk);
  endtask

  task automatic right_try(code_t e);
    send_entry(e);
    tries_exp++;
    check_bit("bolt", bolt, 1'b1);
    @(negedge clk);
    check_bit("bolt", bolt, 1'b0);  // Two cycles after the pulse.
  endtask

  task automatic wrong_try(code_t e);
    send_entry(e);
    tries_exp++;
    @(negedge clk);
    for (int i = 0; i <= WRONG_CYCLES; i++) begin
      check_bit("bolt", bolt, 1'b1);
      check_bit("keypad_en", keypad_en, 1'b0);
      check_display(display, marks(tries_exp));
      @(negedge clk);
    end
    if (tries_exp >= MAX_TRIES) begin
      for (int i = 0; i <= LOCKOUT_CYCLES; i++) begin
        check_bit("bolt", bolt, 1'b1);
        check_bit("keypad_en", keypad_en, 1'b0);
        check_display(display, marks(MAX_TRIES));
        @(negedge clk);
      end
      tries_exp = 0;
    end
    check_bit("keypad_en", keypad_en, 1'b1);
    check_bit("bolt", bolt, 1'b1);
    check_display(display, DISPLAY_BLANK);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic unlock_with_ghosts();
    code_t c;
    reset_dut();
    c = random_code(6);
    load_codes(c, '1, '1, '1);
    right_try(ghost_entry(c, 6, $urandom_range(0, CODE_DIGITS - 6)));
  endtask

  task automatic lockout_after_wrong_codes();
    code_t c;
    reset_dut();
    c = random_code(6);
    load_codes(c, '1, '1, '1);
    for (int i = 0; i < MAX_TRIES; i++) begin
      wrong_try(miss_entry(c[0]));
    end
    right_try(ghost_entry(c, 6, $urandom_range(0, CODE_DIGITS - 6)));
  endtask

  task automatic error_entry_beep();
    code_t c;
    code_t e;
    reset_dut();
    c = random_code(5);
    load_codes(c, '1, '1, '1);
    e = miss_entry(c[0]);
    e[0] = 4'hE;
    send_entry(e);
    for (int i = 0; i <= BEEP_CYCLES; i++) begin
      check_bit("beep", beep, 1'b1);
      check_display(display, DISPLAY_BLANK);
      @(negedge clk);
    end
    check_bit("beep", beep, 1'b0);
    check_bit("keypad_en", keypad_en, 1'b1);
    wrong_try(miss_entry(c[0]));  // Error entries leave the try count alone.
  endtask

  task automatic button_unlock_relock();
    reset_dut();
    press_button(DEBOUNCE_CYCLES);
    check_bit("keypad_en", keypad_en, 1'b1);
    press_button(DEBOUNCE_CYCLES + 1);
    check_bit("bolt", bolt, 1'b0);
    press_button(DEBOUNCE_CYCLES);
    check_bit("bolt", bolt, 1'b0);
    press_button(DEBOUNCE_CYCLES + 1);
    check_bit("bolt", bolt, 1'b1);
    check_bit("keypad_en", keypad_en, 1'b1);
  endtask

  task automatic door_timers();
    reset_dut();
    press_button(DEBOUNCE_CYCLES + 1);
    check_bit("bolt", bolt, 1'b0);
    repeat (AUTO_LOCK_CYCLES) begin
      @(negedge clk);
      check_bit("bolt", bolt, 1'b0);
    end
    @(negedge clk);
    check_bit("bolt", bolt, 1'b1);
    check_bit("keypad_en", keypad_en, 1'b1);
    press_button(DEBOUNCE_CYCLES + 1);
    door_open = 1'b1;
    @(negedge clk);
    check_bit("beep", beep, 1'b0);
    repeat (OPEN_ALARM_CYCLES) begin
      @(negedge clk);
      check_bit("beep", beep, 1'b0);
    end
    @(negedge clk);
    check_bit("beep", beep, 1'b1);
    door_open = 1'b0;
    @(negedge clk);
    check_bit("beep", beep, 1'b0);
    check_bit("bolt", bolt, 1'b0);
    wait_locked();
  endtask

  task automatic code_reload();
    code_t short_c;
    code_t long_c;
    code_t e;
    reset_dut();
    short_c = random_code(3);
    long_c  = random_code(MAX_CODE_LEN);
    load_codes('1, short_c, long_c, '1);
    e = '1;
    e[2:0] = short_c[2:0];
    wrong_try(e);
    right_try(ghost_entry(long_c, MAX_CODE_LEN, $urandom_range(0, CODE_DIGITS - MAX_CODE_LEN)));
  endtask

  initial begin
    cycles      = 0;
    tries_exp   = 0;
    rst         = 1'b1;
    door_open   = 1'b0;
    inside_button = 1'b0;
    code_load   = 1'b0;
    entry_valid = 1'b0;
    entry_value = '1;
    for (int s = 0; s < NUM_CODES; s++) begin
      code_in[s] = '1;
    end
    void'($urandom(32'h8362_a92a));
    unlock_with_ghosts();
    lockout_after_wrong_codes();
    error_entry_beep();
    button_unlock_relock();
    door_timers();
    code_reload();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  localparam time HALF_PERIOD = 50ns;  // 100 ns period.

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

// ==== src.f ====
logic/lock_cfg_pkg.sv
logic/lock_types_pkg.sv
logic/code_store.sv
logic/code_matcher.sv
logic/door_fsm.sv
logic/door_lock_top.sv
sim/tb_clock.sv
sim/door_lock_properties.sv
sim/door_lock_tb.sv
